/* common/rv_pkg.sv */
package rv_pkg;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One fetched word, viewed in each encoding format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_t;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'b000,
    ALU_SUB = 3'b001,
    ALU_AND = 3'b010,
    ALU_OR  = 3'b011,
    ALU_XOR = 3'b100,
    ALU_SLT = 3'b101
  } alu_op_t;

  typedef enum logic [1:0] {
    SRC_A_PC     = 2'b00,
    SRC_A_OLD_PC = 2'b01,
    SRC_A_RS1    = 2'b10,
    SRC_A_ZERO   = 2'b11
  } alu_src_a_t;

  typedef enum logic [1:0] {
    SRC_B_RS2  = 2'b00,
    SRC_B_IMM  = 2'b01,
    SRC_B_FOUR = 2'b10
  } alu_src_b_t;

  typedef enum logic [1:0] {
    RES_ALU_OUT    = 2'b00,
    RES_DATA       = 2'b01,
    RES_ALU_RESULT = 2'b10
  } result_src_t;

  typedef enum logic {
    ADR_PC     = 1'b0,
    ADR_RESULT = 1'b1
  } adr_src_t;

  typedef enum logic [3:0] {
    S_FETCH,
    S_DECODE,
    S_MEM_ADR,
    S_MEM_READ,
    S_MEM_WB,
    S_MEM_WRITE,
    S_EXEC_R,
    S_EXEC_I,
    S_ALU_WB,
    S_BRANCH,
    S_JAL,
    S_HALT
  } fsm_state_t;

endpackage

/* common/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if
  import rv_pkg::*;
  ();

  logic        pc_write;
  logic        ir_write;
  logic        reg_write;
  logic        mem_write;
  adr_src_t    adr_src;
  alu_src_a_t  alu_src_a;
  alu_src_b_t  alu_src_b;
  alu_op_t     alu_op;
  result_src_t result_src;

  // Control side
  modport ctrl (
    output pc_write, ir_write, reg_write, mem_write,
    output adr_src, alu_src_a, alu_src_b, alu_op, result_src
  );

  // Datapath side
  modport dp (
    input pc_write, ir_write, reg_write, mem_write,
    input adr_src, alu_src_a, alu_src_b, alu_op, result_src
  );

endinterface

/* source/alu.sv */
`timescale 1ns/1ps

module alu
  import rv_pkg::*;
  (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_op_t     op,
  output logic [31:0] result,
  output logic        zero
);

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
      default: result = 32'b0;
    endcase
  end

  // Used by branches after a subtract
  assign zero = (result == 32'b0);

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= 32'b0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 always reads as zero
  assign rdata1 = (rs1 == 5'd0) ? 32'b0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 32'b0 : regs[rs2];

endmodule

/* source/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
  import rv_pkg::*;
  (
  input  instr_t      instr,
  output opcode_t     opcode,
  output logic [2:0]  funct3,
  output logic        funct7_b5,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  rd,
  output logic [31:0] imm_ext
);

  // Register and function fields sit at the same place in every format
  assign opcode    = opcode_t'(instr.r.opcode);
  assign funct3    = instr.r.funct3;
  assign funct7_b5 = instr.r.funct7[5];
  assign rs1       = instr.r.rs1;
  assign rs2       = instr.r.rs2;
  assign rd        = instr.r.rd;

  always_comb begin
    case (opcode)
      OPC_OP_IMM,
      OPC_LOAD: begin
        imm_ext = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      OPC_STORE: begin
        imm_ext = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      end
      OPC_BRANCH: begin
        imm_ext = {
          {19{instr.b.imm_12}},
          instr.b.imm_12,
          instr.b.imm_11,
          instr.b.imm_10_5,
          instr.b.imm_4_1,
          1'b0
        };
      end
      OPC_LUI: begin
        imm_ext = {instr.u.imm_31_12, 12'b0};
      end
      OPC_JAL: begin
        imm_ext = {
          {11{instr.j.imm_20}},
          instr.j.imm_20,
          instr.j.imm_19_12,
          instr.j.imm_11,
          instr.j.imm_10_1,
          1'b0
        };
      end
      // R-type and SYSTEM carry no immediate
      default: begin
        imm_ext = 32'b0;
      end
    endcase
  end

endmodule

/* control/control_fsm.sv */
`timescale 1ns/1ps

module control_fsm
  import rv_pkg::*;
  (
  input  logic         clk,
  input  logic         rst_n,
  input  opcode_t      opcode,
  input  logic [2:0]   funct3,
  input  logic         funct7_b5,
  input  logic         zero,
  ctrl_if.ctrl         ctrl,
  output logic         halted
);

  fsm_state_t state;
  fsm_state_t state_next;
  alu_op_t    dec_alu_op;
  logic       branch_taken;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_FETCH;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = S_FETCH;
    case (state)
      S_FETCH:  state_next = S_DECODE;
      S_DECODE: begin
        case (opcode)
          OPC_OP:                state_next = S_EXEC_R;
          OPC_OP_IMM, OPC_LUI:   state_next = S_EXEC_I;
          OPC_LOAD, OPC_STORE:   state_next = S_MEM_ADR;
          OPC_BRANCH:            state_next = S_BRANCH;
          OPC_JAL:               state_next = S_JAL;
          default:               state_next = S_HALT;
        endcase
      end
      S_MEM_ADR:   state_next = (opcode == OPC_LOAD) ? S_MEM_READ : S_MEM_WRITE;
      S_MEM_READ:  state_next = S_MEM_WB;
      S_EXEC_R,
      S_EXEC_I:    state_next = S_ALU_WB;
      S_HALT:      state_next = S_HALT;
      default:     state_next = S_FETCH;
    endcase
  end

  // ALU decoder for the execute states
  always_comb begin
    case (funct3)
      3'b000:  dec_alu_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
      3'b010:  dec_alu_op = ALU_SLT;
      3'b100:  dec_alu_op = ALU_XOR;
      3'b110:  dec_alu_op = ALU_OR;
      3'b111:  dec_alu_op = ALU_AND;
      default: dec_alu_op = ALU_ADD;
    endcase
    // funct3 bits of LUI belong to the immediate
    if (opcode == OPC_LUI) begin
      dec_alu_op = ALU_ADD;
    end
  end

  // funct3[0] set means BNE
  assign branch_taken = funct3[0] ? !zero : zero;

  always_comb begin
    ctrl.pc_write   = 1'b0;
    ctrl.ir_write   = 1'b0;
    ctrl.reg_write  = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.adr_src    = ADR_PC;
    ctrl.alu_src_a  = SRC_A_PC;
    ctrl.alu_src_b  = SRC_B_RS2;
    ctrl.alu_op     = ALU_ADD;
    ctrl.result_src = RES_ALU_OUT;
    case (state)
      S_FETCH: begin
        ctrl.ir_write   = 1'b1;
        ctrl.pc_write   = 1'b1;
        ctrl.alu_src_b  = SRC_B_FOUR;
        ctrl.result_src = RES_ALU_RESULT;
      end
      // Branch and jump target is formed here into the ALU output register
      S_DECODE: begin
        ctrl.alu_src_a = SRC_A_OLD_PC;
        ctrl.alu_src_b = SRC_B_IMM;
      end
      S_MEM_ADR: begin
        ctrl.alu_src_a = SRC_A_RS1;
        ctrl.alu_src_b = SRC_B_IMM;
      end
      S_MEM_READ: begin
        ctrl.adr_src = ADR_RESULT;
      end
      S_MEM_WB: begin
        ctrl.result_src = RES_DATA;
        ctrl.reg_write  = 1'b1;
      end
      S_MEM_WRITE: begin
        ctrl.adr_src   = ADR_RESULT;
        ctrl.mem_write = 1'b1;
      end
      S_EXEC_R: begin
        ctrl.alu_src_a = SRC_A_RS1;
        ctrl.alu_op    = dec_alu_op;
      end
      S_EXEC_I: begin
        ctrl.alu_src_a = (opcode == OPC_LUI) ? SRC_A_ZERO : SRC_A_RS1;
        ctrl.alu_src_b = SRC_B_IMM;
        ctrl.alu_op    = dec_alu_op;
      end
      S_ALU_WB: begin
        ctrl.reg_write = 1'b1;
      end
      S_BRANCH: begin
        ctrl.alu_src_a = SRC_A_RS1;
        ctrl.alu_op    = ALU_SUB;
        ctrl.pc_write  = branch_taken;
      end
      S_JAL: begin
        ctrl.pc_write  = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

  assign halted = (state == S_HALT);

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
  (
  input  logic        clk,
  input  logic        rst_n,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  output logic        mem_we,
  input  logic [31:0] mem_rdata,
  output logic        halted
);

  ctrl_if ctrl ();

  logic [31:0] pc;
  logic [31:0] old_pc;
  instr_t      instr;
  logic [31:0] data_reg;
  logic [31:0] a_reg;
  logic [31:0] b_reg;
  logic [31:0] alu_out;

  opcode_t     opcode;
  logic [2:0]  funct3;
  logic        funct7_b5;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [31:0] imm_ext;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        zero;
  logic [31:0] result;
  logic [31:0] rf_wdata;

  control_fsm i_control_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .opcode    (opcode),
    .funct3    (funct3),
    .funct7_b5 (funct7_b5),
    .zero      (zero),
    .ctrl      (ctrl.ctrl),
    .halted    (halted)
  );

  instr_decode i_instr_decode (
    .instr     (instr),
    .opcode    (opcode),
    .funct3    (funct3),
    .funct7_b5 (funct7_b5),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm_ext   (imm_ext)
  );

  reg_file i_reg_file (
    .clk    (clk),
    .rst_n  (rst_n),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .we     (ctrl.reg_write),
    .wdata  (rf_wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  alu i_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .zero   (zero)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (ctrl.pc_write) begin
      pc <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      instr  <= mem_rdata;
      old_pc <= pc;
    end
  end

  // Staging registers between the cycles of one instruction
  always_ff @(posedge clk) begin
    data_reg <= mem_rdata;
    a_reg    <= rdata1;
    b_reg    <= rdata2;
    alu_out  <= alu_result;
  end

  always_comb begin
    case (ctrl.alu_src_a)
      SRC_A_PC:     alu_a = pc;
      SRC_A_OLD_PC: alu_a = old_pc;
      SRC_A_RS1:    alu_a = a_reg;
      default:      alu_a = 32'b0;
    endcase
  end

  always_comb begin
    case (ctrl.alu_src_b)
      SRC_B_RS2:  alu_b = b_reg;
      SRC_B_IMM:  alu_b = imm_ext;
      SRC_B_FOUR: alu_b = 32'd4;
      default:    alu_b = 32'b0;
    endcase
  end

  always_comb begin
    case (ctrl.result_src)
      RES_ALU_OUT:    result = alu_out;
      RES_DATA:       result = data_reg;
      RES_ALU_RESULT: result = alu_result;
      default:        result = alu_out;
    endcase
  end

  // JAL loads the PC and rd together; the link is the PC that fetch already advanced
  assign rf_wdata = ctrl.pc_write ? pc : result;

  assign mem_addr  = (ctrl.adr_src == ADR_RESULT) ? result : pc;
  assign mem_wdata = b_reg;
  assign mem_we    = ctrl.mem_write;

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* test/rv_core_sva.sv */
`timescale 1ns/1ps

module rv_core_sva
  import rv_pkg::*;
  (
  input logic        clk,
  input logic        rst_n,
  input logic        mem_we,
  input logic [31:0] mem_addr,
  input logic        halted,
  input fsm_state_t  state
);

  a_reset_quiet: assert property (
    @(posedge clk) !rst_n |-> !mem_we && !halted
  ) else $error("mem_we or halted high during reset");

  // First cycle out of reset fetches from address zero
  a_first_fetch: assert property (
    @(posedge clk) $rose(rst_n) |-> (state == S_FETCH) && (mem_addr == 32'h0) && !mem_we
  ) else $error("first fetch after reset is not a fetch from address zero");

  a_halted_sticky: assert property (
    @(posedge clk) disable iff (!rst_n) halted |=> halted
  ) else $error("halted dropped after it was raised");

  a_no_write_in_fetch: assert property (
    @(posedge clk) disable iff (!rst_n) (state == S_FETCH) |-> !mem_we
  ) else $error("memory write during FETCH");

  a_store_aligned: assert property (
    @(posedge clk) disable iff (!rst_n) mem_we |-> (mem_addr[1:0] == 2'b00)
  ) else $error("store address is not word-aligned");

endmodule

/* test/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core
  import rv_pkg::*;
  ();

  localparam int OPC_I     = 'h13;
  localparam int DATA_WORD = 128;
  localparam int LOOP_CNT  = 5;

  logic        clk;
  logic        rst_n;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_we;
  logic [31:0] mem_rdata;
  logic        halted;

  logic [31:0] image [256];
  logic [31:0] mem [256];
  logic [31:0] ref_mem [256];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  integer      seed;
  int          prog_len;
  int          exp_stores;
  int          store_idx;
  int          errors;
  int          cycle_count;
  int          timeout_cycles;
  logic        halted_d;

  tb_clock i_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rv_core i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we),
    .mem_rdata (mem_rdata),
    .halted    (halted)
  );

  bind rv_core rv_core_sva i_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .halted   (halted),
    .state    (i_control_fsm.state)
  );

  // Unified memory that loads the image while reset is held
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < 256; k++) begin
        mem[k] <= image[k];
      end
    end else if (mem_we) begin
      mem[mem_addr[9:2]] <= mem_wdata;
    end
  end

  assign mem_rdata = rst_n ? mem[mem_addr[9:2]] : 32'h0;

  function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
                                        input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input int opc, input int f3, input int rd,
                                        input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
                                        input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic logic [31:0] enc_j(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic emit(input logic [31:0] word);
    image[prog_len] = word;
    prog_len++;
  endtask

  // Store rs at the output pointer x10 and advance it
  task automatic emit_store(input int rs);
    emit(enc_s(rs, 10, 0));
    emit(enc_i(OPC_I, 0, 10, 10, 4));
  endtask

  task automatic build_program();
    int loop_pc;
    for (int k = 0; k < 256; k++) begin
      image[k] = 32'h0;
    end
    prog_len = 0;
    for (int k = 0; k < 4; k++) begin
      image[DATA_WORD + k] = $random(seed);
    end
    emit(enc_i(OPC_I, 0, 10, 0, 'h300));
    emit(enc_i(OPC_I, 0, 11, 0, DATA_WORD * 4));
    // Arithmetic with SLT on negative values and writes to x0
    emit(enc_i(OPC_I, 0, 1, 0, 25));
    emit(enc_i(OPC_I, 0, 2, 0, -7));
    emit(enc_r('h00, 0, 3, 1, 2));
    emit(enc_r('h20, 0, 4, 2, 1));
    emit(enc_r('h00, 2, 5, 2, 1));
    emit(enc_r('h00, 2, 6, 1, 2));
    emit(enc_r('h00, 2, 7, 4, 2));
    emit(enc_r('h00, 7, 8, 1, 2));
    emit(enc_r('h00, 6, 9, 1, 2));
    emit(enc_r('h00, 4, 12, 1, 2));
    emit(enc_r('h00, 0, 0, 1, 1));
    emit(enc_i(OPC_I, 0, 0, 0, 5));
    emit_store(3);
    emit_store(4);
    emit_store(5);
    emit_store(6);
    emit_store(7);
    emit_store(8);
    emit_store(9);
    emit_store(12);
    emit_store(0);
    // Loads of the random data words
    emit(enc_i('h03, 2, 13, 11, 0));
    emit(enc_i('h03, 2, 14, 11, 4));
    emit(enc_i('h03, 2, 15, 11, 8));
    emit(enc_i('h03, 2, 16, 11, 12));
    emit(enc_r('h00, 0, 17, 13, 14));
    emit(enc_r('h00, 4, 18, 15, 16));
    emit(enc_r('h20, 0, 19, 17, 18));
    emit_store(13);
    emit_store(17);
    emit_store(18);
    emit_store(19);
    // Branches taken and not taken
    emit(enc_b(0, 1, 1, 8));
    emit(enc_i(OPC_I, 0, 20, 0, 1));
    emit(enc_b(1, 1, 1, 8));
    emit(enc_i(OPC_I, 0, 21, 0, 2));
    emit(enc_b(0, 1, 2, 8));
    emit(enc_i(OPC_I, 0, 22, 0, 3));
    emit(enc_b(1, 1, 2, 8));
    emit(enc_i(OPC_I, 0, 23, 0, 4));
    emit_store(20);
    emit_store(21);
    emit_store(22);
    emit_store(23);
    // Counted loop with one store per pass
    emit(enc_i(OPC_I, 0, 24, 0, LOOP_CNT));
    emit(enc_i(OPC_I, 0, 25, 0, 0));
    loop_pc = prog_len * 4;
    emit(enc_r('h00, 0, 25, 25, 24));
    emit_store(25);
    emit(enc_i(OPC_I, 0, 24, 24, -1));
    emit(enc_b(1, 24, 0, loop_pc - prog_len * 4));
    emit_store(25);
    // JAL skips one instruction before the LUI
    emit(enc_j(26, 8));
    emit(enc_i(OPC_I, 0, 27, 0, 9));
    emit(enc_u(28, 'hABCDE));
    emit(enc_i(OPC_I, 0, 29, 28, -1));
    emit(enc_s(26, 10, 0));
    emit(enc_s(27, 10, 4));
    emit(enc_s(28, 10, 8));
    emit(enc_s(29, 10, 12));
    emit(enc_i(OPC_I, 0, 10, 10, 16));
    emit(32'h0000_0073);
  endtask

  // ISA model of the reduced RV32I set that runs over the same image
  function automatic int run_reference();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] wb;
    logic        wr;
    logic        done;
    int          steps;
    for (int k = 0; k < 32; k++) begin
      regs[k] = 32'h0;
    end
    for (int k = 0; k < 256; k++) begin
      ref_mem[k] = image[k];
    end
    pc = 32'h0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 10000) begin
      ins = ref_mem[pc[9:2]];
      a = regs[ins[19:15]];
      b = regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      wr = 1'b0;
      wb = 32'h0;
      next_pc = pc + 32'd4;
      case (ins[6:0])
        7'h33, 7'h13: begin
          wr = 1'b1;
          if (ins[6:0] == 7'h13) begin
            b = imm_i;
          end
          case (ins[14:12])
            3'b000:  wb = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
            3'b010:  wb = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  wb = a ^ b;
            3'b110:  wb = a | b;
            default: wb = a & b;
          endcase
        end
        7'h37: begin
          wr = 1'b1;
          wb = {ins[31:12], 12'h0};
        end
        7'h03: begin
          addr = a + imm_i;
          wr = 1'b1;
          wb = ref_mem[addr[9:2]];
        end
        7'h23: begin
          addr = a + imm_s;
          ref_mem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        7'h63: begin
          if (ins[12] ? (a != b) : (a == b)) begin
            next_pc = pc + imm_b;
          end
        end
        7'h6f: begin
          wr = 1'b1;
          wb = pc + 32'd4;
          next_pc = pc + imm_j;
        end
        // ECALL ends the program
        default: done = 1'b1;
      endcase
      if (wr && ins[11:7] != 5'd0) begin
        regs[ins[11:7]] = wb;
      end
      pc = next_pc;
      steps++;
    end
    return exp_addr.size();
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // Stores are compared in the order in which they leave the core
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (halted && !halted_d) begin
        check("store_count", store_idx, exp_stores);
      end
      halted_d = halted;
      if (mem_we === 1'b1) begin
        if (halted) begin
          $display("Error: a store appeared after the core halted");
          errors++;
        end else if (store_idx >= exp_stores) begin
          $display("Error: the core made more stores than the reference model");
          errors++;
        end else begin
          check("mem_addr", mem_addr, exp_addr[store_idx]);
          check("mem_wdata", mem_wdata, exp_data[store_idx]);
        end
        store_idx++;
      end
    end
  end

  initial begin
    seed = 32'hfcd7;
    errors = 0;
    store_idx = 0;
    cycle_count = 0;
    halted_d = 1'b0;
    build_program();
    exp_stores = run_reference();
    timeout_cycles = prog_len * 5 * LOOP_CNT + 20;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check("mem_addr", mem_addr, 32'h0);
    check("mem_we", {31'b0, mem_we}, 32'h0);
    check("halted", {31'b0, halted}, 32'h0);
    while (halted !== 1'b1 && cycle_count < timeout_cycles) begin
      @(negedge clk);
      cycle_count++;
    end
    if (halted !== 1'b1) begin
      $display("Error: halted never rose within %0d cycles", timeout_cycles);
      errors++;
    end else begin
      // A few idle cycles to catch any late store
      repeat (8) @(negedge clk);
      check("store_count", store_idx, exp_stores);
      for (int k = 0; k < 256; k++) begin
        check($sformatf("mem[%0d]", k), mem[k], ref_mem[k]);
      end
    end
    $display("Errors: %0d, stores seen: %0d of %0d, cycles: %0d",
             errors, store_idx, exp_stores, cycle_count);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
common/rv_pkg.sv
common/ctrl_if.sv
source/alu.sv
source/reg_file.sv
source/instr_decode.sv
control/control_fsm.sv
source/rv_core.sv
test/tb_clock.sv
test/rv_core_sva.sv
test/tb_rv_core.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_rv_core
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
